//--- compile.f
src/aether_isa_pkg.sv
src/aether_data_pkg.sv
src/input_buffer.sv
src/aether_regfile.sv
src/aether_decoder.sv
src/conv_engine.sv
src/aether_engine.sv
sim/tb_aether_engine.sv

//--- sim/tb_aether_engine.sv
`timescale 1ns/1ps

module tb_aether_engine;

  // ----------------------------------------
  // Test tables
  // ----------------------------------------

  // Optional register write, then a read back
  typedef struct packed {
    logic        do_wr;
    logic [3:0]  addr;
    logic [15:0] wdata;
    logic [15:0] exp_data;
  } reg_step_t;

  // One convolution run
  typedef struct packed {
    logic [3:0] size;     // N
    logic       neg_only; // Weights from -128 to -1
  } conv_case_t;

  localparam int RegSteps  = 11;
  localparam int ConvCases = 4;
  localparam int RerunCase = 1; // Case repeated after the engine reset

  reg_step_t reg_table [RegSteps] = '{
    // wr    addr                        wdata     read back
    {1'b0, aether_isa_pkg::REG_VERSN, 16'h0000, 16'h6C00},
    {1'b0, aether_isa_pkg::REG_HWRID, 16'h0000, 16'hB2E9},
    {1'b0, aether_isa_pkg::REG_CPRM1, 16'h0000, 16'h0003}, // Reset size
    {1'b0, aether_isa_pkg::REG_STATS, 16'h0000, 16'h0000},
    {1'b0, 4'd9,                      16'h0000, 16'h0000}, // Unused addr
    {1'b1, aether_isa_pkg::REG_VERSN, 16'h1234, 16'h6C00}, // Read only
    {1'b1, aether_isa_pkg::REG_HWRID, 16'h0000, 16'hB2E9},
    {1'b1, aether_isa_pkg::REG_CPRM1, 16'h0007, 16'h0007},
    {1'b1, aether_isa_pkg::REG_CPRM1, 16'h0014, 16'h000B}, // Clamped down
    {1'b1, aether_isa_pkg::REG_CPRM1, 16'h0001, 16'h0003}, // Clamped up
    {1'b1, aether_isa_pkg::REG_CPRM1, 16'h0100, 16'h000B}
  };

  conv_case_t conv_table [ConvCases] = '{
    {4'd3,  1'b0},
    {4'd5,  1'b1},
    {4'd8,  1'b0},
    {4'd11, 1'b1}
  };

  // ----------------------------------------
  // DUT and clock
  // ----------------------------------------

  logic        clk_i;
  logic        rst_n_i;
  logic [3:0]  instruction_i;
  logic [3:0]  param_1_i;
  logic [15:0] param_2_i;
  logic [15:0] data_o;
  logic        interrupt_o;

  int checks;
  int reg_errors;
  int result_errors;
  int flag_errors;
  int cycles;
  int cycle_limit;

  // Model copies of the loaded data
  logic signed [7:0] pixels  [128];
  logic signed [7:0] weights [9];

  aether_engine #(
    .BufferWords   (64),
    .MaxMatrixSize (11),
    .ResultDepth   (81)
  ) DUT (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .instruction_i (instruction_i),
    .param_1_i     (param_1_i),
    .param_2_i     (param_2_i),
    .data_o        (data_o),
    .interrupt_o   (interrupt_o)
  );

  always #10 clk_i = ~clk_i; // 20 ns period

  // Run limit from the case budgets
  always @(posedge clk_i)
  begin
    cycles = cycles + 1;
    if (cycles >= cycle_limit)
    begin
      $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("Result: FAILED");
      $finish;
    end
  end

  // ----------------------------------------
  // Helpers
  // ----------------------------------------

  function automatic int case_budget(input int n);
    return (n - 2) * (n - 2) * 12 + 200;
  endfunction

  // Sum over the 3x3 window, low 16 bits kept
  function automatic logic [15:0] expected_result(input int n, input int r, input int c);
    int sum;
    sum = 0;
    for (int kr = 0; kr < 3; kr++)
      for (int kc = 0; kc < 3; kc++)
        sum += int'(weights[kr * 3 + kc]) * int'(pixels[(r + kr) * n + c + kc]);
    return 16'(sum);
  endfunction

  // Presents one instruction for one edge, then NOP
  task automatic issue(input aether_isa_pkg::opcode_e op, input logic [3:0] p1,
                       input logic [15:0] p2);
    instruction_i = op;
    param_1_i     = p1;
    param_2_i     = p2;
    @(posedge clk_i);
    #2;
    instruction_i = aether_isa_pkg::OP_NOP;
    param_1_i     = '0;
    param_2_i     = '0;
  endtask

  // Read value lands on data_o three edges later
  task automatic read_back(input aether_isa_pkg::opcode_e op, input logic [3:0] p1,
                           input logic [15:0] p2, output logic [15:0] value);
    issue(op, p1, p2);
    repeat (3) @(posedge clk_i);
    #2;
    value = data_o;
  endtask

  // kind 0 register, 1 result, 2 flag
  task automatic check_value(input string name, input logic [15:0] got,
                             input logic [15:0] want, input int kind);
    checks++;
    assert (got === want)
    else
    begin
      $display("[FAIL] %s got 16'h%04h, expected 16'h%04h", name, got, want);
      if (kind == 0)
        reg_errors++;
      else if (kind == 1)
        result_errors++;
      else
        flag_errors++;
    end
  endtask

  // Polls STATS until done, first poll must see busy
  task automatic wait_done();
    logic [15:0] stats;
    bit          first;
    stats = '0;
    first = 1'b1;
    while (!stats[1])
    begin
      read_back(aether_isa_pkg::OP_READ_REG, aether_isa_pkg::REG_STATS, 16'h0, stats);
      if (first)
      begin
        check_value("STATS", stats, 16'h0001, 2); // Busy, done dropped by run
        check_value("interrupt_o", {15'b0, interrupt_o}, 16'h0000, 2);
      end
      first = 1'b0;
    end
    check_value("STATS", stats, 16'h0002, 2);
    check_value("interrupt_o", {15'b0, interrupt_o}, 16'h0001, 2);
  endtask

  task automatic run_case(input conv_case_t tc);
    int          n;
    int          outs;
    int          words;
    logic [15:0] value;
    n     = int'(tc.size);
    outs  = n - 2;
    words = (n * n + 1) / 2;
    issue(aether_isa_pkg::OP_WRITE_REG, aether_isa_pkg::REG_CPRM1, 16'(n));

    // Two pixels per word, even pixel low
    for (int k = 0; k < 2 * words; k++)
      pixels[k] = 8'($urandom);
    for (int w = 0; w < words; w++)
      issue((w == 0) ? aether_isa_pkg::OP_LOAD_START : aether_isa_pkg::OP_LOAD_CONT,
            4'h0, {pixels[2 * w + 1], pixels[2 * w]});

    for (int t = 0; t < 9; t++)
    begin
      if (tc.neg_only)
        weights[t] = 8'(-(1 + int'($urandom % 128)));
      else
        weights[t] = 8'($urandom);
      issue(aether_isa_pkg::OP_LOAD_WEIGHT, 4'(t), {8'h00, weights[t]});
    end

    issue(aether_isa_pkg::OP_RUN_CONV, 4'h0, 16'h0);
    wait_done();

    for (int i = 0; i < outs * outs; i++)
    begin
      read_back(aether_isa_pkg::OP_READ_RESULT, 4'h0, 16'(i), value);
      check_value($sformatf("data_o result %0d (N=%0d)", i, n), value,
                  expected_result(n, i / outs, i % outs), 1);
    end

    // Done level holds until the next run or clear
    check_value("interrupt_o", {15'b0, interrupt_o}, 16'h0001, 2);
    read_back(aether_isa_pkg::OP_READ_REG, aether_isa_pkg::REG_STATS, 16'h0, value);
    check_value("STATS", value, 16'h0002, 2);
  endtask

  // ----------------------------------------
  // Main sequence
  // ----------------------------------------

  initial
  begin : main_seq
    logic [15:0] value;
    void'($urandom(32'h9de0_dafb));
    clk_i         = 1'b0;
    rst_n_i       = 1'b0;
    instruction_i = '0;
    param_1_i     = '0;
    param_2_i     = '0;
    checks        = 0;
    reg_errors    = 0;
    result_errors = 0;
    flag_errors   = 0;
    cycles        = 0;
    cycle_limit   = 500 + case_budget(int'(conv_table[RerunCase].size));
    for (int i = 0; i < ConvCases; i++)
      cycle_limit += case_budget(int'(conv_table[i].size));

    repeat (10) @(posedge clk_i);
    #2;
    rst_n_i = 1'b1;

    check_value("interrupt_o", {15'b0, interrupt_o}, 16'h0000, 2);
    check_value("data_o", data_o, 16'h0000, 0);

    // Identity, CPRM1 clamp and read-only registers
    for (int i = 0; i < RegSteps; i++)
    begin
      if (reg_table[i].do_wr)
        issue(aether_isa_pkg::OP_WRITE_REG, reg_table[i].addr, reg_table[i].wdata);
      read_back(aether_isa_pkg::OP_READ_REG, reg_table[i].addr, 16'h0, value);
      check_value($sformatf("data_o reg %0d", reg_table[i].addr), value,
                  reg_table[i].exp_data, 0);
    end

    for (int i = 0; i < ConvCases; i++)
      run_case(conv_table[i]);

    // Engine reset drops done and the interrupt
    issue(aether_isa_pkg::OP_RESET_CONV, 4'h0, 16'h0);
    read_back(aether_isa_pkg::OP_READ_REG, aether_isa_pkg::REG_STATS, 16'h0, value);
    check_value("STATS", value, 16'h0000, 2);
    check_value("interrupt_o", {15'b0, interrupt_o}, 16'h0000, 2);

    run_case(conv_table[RerunCase]);

    $display("Checks: %0d, register errors: %0d, result errors: %0d, flag errors: %0d",
             checks, reg_errors, result_errors, flag_errors);
    if (reg_errors + result_errors + flag_errors == 0)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

endmodule

//--- src/aether_data_pkg.sv
package aether_data_pkg;

  // ----------------------------------------
  // Datapath types
  // ----------------------------------------

  // One activation, two of them per buffer word
  typedef logic signed [7:0] pixel_t;

  // One kernel tap
  typedef logic signed [7:0] weight_t;

  // MAC accumulator, nine 16-bit products need 20 bits
  typedef logic signed [19:0] acc_t;

  // Stored result, low half of the accumulator
  typedef logic [15:0] result_t;

  // Square kernel, fixed 3x3
  localparam int KERNEL_SIZE = 3;

  // ----------------------------------------
  // Engine status
  // ----------------------------------------

  // Busy lands in bit 0, done in bit 1 of STATS
  typedef struct packed {
    logic done; // Last result written
    logic busy; // Fetch or drain in progress
  } conv_status_t;

endpackage

//--- src/aether_decoder.sv
`timescale 1ns/1ps

module aether_decoder (
  input  logic                     clk_i,
  input  logic                     rst_n_i,

  // Host side
  input  logic [3:0]               instruction_i,
  input  logic [3:0]               param_1_i,
  input  logic [15:0]              param_2_i,

  // Read data returns
  input  logic [15:0]              reg_rdata_i,
  input  aether_data_pkg::result_t res_rdata_i,

  // Command aligned with the strobes
  output aether_isa_pkg::cmd_t     cmd_o,

  output logic                     reg_wr_o,
  output logic                     reg_rd_o,
  output logic                     load_start_o,
  output logic                     load_cont_o,
  output logic                     weight_wr_o,
  output logic                     run_o,
  output logic                     clear_o,
  output logic                     res_rd_o,

  output logic [15:0]              data_o
);

  aether_isa_pkg::cmd_t cmd_q; // Input stage
  logic pend_reg_q;            // Register read data arrives next
  logic pend_res_q;            // Result read data arrives next

  // ----------------------------------------
  // Input register and strobe decode
  // ----------------------------------------

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      cmd_q        <= '0; // Decodes as NOP
      reg_wr_o     <= 1'b0;
      reg_rd_o     <= 1'b0;
      load_start_o <= 1'b0;
      load_cont_o  <= 1'b0;
      weight_wr_o  <= 1'b0;
      run_o        <= 1'b0;
      clear_o      <= 1'b0;
      res_rd_o     <= 1'b0;
    end
    else
    begin
      cmd_q.opcode  <= aether_isa_pkg::opcode_e'(instruction_i);
      cmd_q.param_1 <= param_1_i;
      cmd_q.param_2 <= param_2_i;

      // One-hot, unknown codes leave all low
      reg_rd_o     <= cmd_q.opcode == aether_isa_pkg::OP_READ_REG;
      reg_wr_o     <= cmd_q.opcode == aether_isa_pkg::OP_WRITE_REG;
      load_start_o <= cmd_q.opcode == aether_isa_pkg::OP_LOAD_START;
      load_cont_o  <= cmd_q.opcode == aether_isa_pkg::OP_LOAD_CONT;
      weight_wr_o  <= cmd_q.opcode == aether_isa_pkg::OP_LOAD_WEIGHT;
      run_o        <= cmd_q.opcode == aether_isa_pkg::OP_RUN_CONV;
      res_rd_o     <= cmd_q.opcode == aether_isa_pkg::OP_READ_RESULT;
      clear_o      <= cmd_q.opcode == aether_isa_pkg::OP_RESET_CONV;
    end
  end

  // Operands follow the strobes by the same cycle
  always_ff @(posedge clk_i)
  begin
    cmd_o <= cmd_q;
  end

  // ----------------------------------------
  // Read return path
  // ----------------------------------------

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      pend_reg_q <= 1'b0;
      pend_res_q <= 1'b0;
      data_o     <= '0;
    end
    else
    begin
      pend_reg_q <= reg_rd_o; // Source registers its data this edge
      pend_res_q <= res_rd_o;
      if (pend_reg_q)
        data_o <= reg_rdata_i;
      else if (pend_res_q)
        data_o <= res_rdata_i;
    end
  end

endmodule

//--- src/aether_engine.sv
`timescale 1ns/1ps

module aether_engine #(
  parameter int BufferWords   = 64, // Input buffer depth in 16-bit words
  parameter int MaxMatrixSize = 11, // Largest N the engine accepts
  parameter int ResultDepth   = 81  // (MaxMatrixSize-2)^2 results
) (
  input  logic        clk_i,
  input  logic        rst_n_i,

  // Host command bus
  input  logic [3:0]  instruction_i,
  input  logic [3:0]  param_1_i,
  input  logic [15:0] param_2_i,

  output logic [15:0] data_o,      // Last read value
  output logic        interrupt_o  // Convolution finished
);

  localparam int BufAddrW = $clog2(BufferWords);
  localparam int ResAddrW = $clog2(ResultDepth);

  // ----------------------------------------
  // Interconnect
  // ----------------------------------------

  aether_isa_pkg::cmd_t          cmd;
  aether_data_pkg::conv_status_t conv_status;
  aether_data_pkg::result_t      res_rdata;

  logic [15:0]         reg_rdata;
  logic [3:0]          cprm1_size;     // Matrix size from CPRM1
  logic [BufAddrW-1:0] buf_raddr;
  logic [15:0]         buf_rdata;

  // Decoder strobes
  logic reg_wr;
  logic reg_rd;
  logic load_start;
  logic load_cont;
  logic weight_wr;
  logic run;
  logic clear;
  logic res_rd;

  // ----------------------------------------
  // Instances
  // ----------------------------------------

  aether_decoder decode_inst (
    .clk_i,
    .rst_n_i,
    .instruction_i,
    .param_1_i,
    .param_2_i,
    .reg_rdata_i  (reg_rdata),
    .res_rdata_i  (res_rdata),
    .cmd_o        (cmd),
    .reg_wr_o     (reg_wr),
    .reg_rd_o     (reg_rd),
    .load_start_o (load_start),
    .load_cont_o  (load_cont),
    .weight_wr_o  (weight_wr),
    .run_o        (run),
    .clear_o      (clear),
    .res_rd_o     (res_rd),
    .data_o
  );

  aether_regfile #(
    .MaxMatrixSize (MaxMatrixSize)
  ) regfile_inst (
    .clk_i,
    .rst_n_i,
    .cmd_i        (cmd),
    .reg_wr_i     (reg_wr),
    .reg_rd_i     (reg_rd),
    .status_i     (conv_status),
    .cprm1_size_o (cprm1_size),
    .reg_rdata_o  (reg_rdata)
  );

  input_buffer #(
    .BufferWords (BufferWords)
  ) buffer_inst (
    .clk_i,
    .rst_n_i,
    .load_start_i (load_start),
    .load_cont_i  (load_cont),
    .wdata_i      (cmd.param_2),
    .raddr_i      (buf_raddr),
    .rdata_o      (buf_rdata)
  );

  conv_engine #(
    .BufferWords   (BufferWords),
    .MaxMatrixSize (MaxMatrixSize),
    .ResultDepth   (ResultDepth)
  ) conv_inst (
    .clk_i,
    .rst_n_i,
    .weight_wr_i  (weight_wr),
    .weight_idx_i (cmd.param_1),
    .weight_i     (aether_data_pkg::weight_t'(cmd.param_2[7:0])),
    .run_i        (run),
    .clear_i      (clear),
    .res_rd_i     (res_rd),
    .res_idx_i    (cmd.param_2[ResAddrW-1:0]),
    .size_i       (cprm1_size),
    .buf_raddr_o  (buf_raddr),
    .buf_rdata_i  (buf_rdata),
    .status_o     (conv_status),
    .res_rdata_o  (res_rdata),
    .done_o       (interrupt_o) // Level until next run or clear
  );

endmodule

//--- src/aether_isa_pkg.sv
package aether_isa_pkg;

  // ----------------------------------------
  // Instruction set
  // ----------------------------------------

  // Host opcodes, one instruction per clock
  typedef enum logic [3:0] {
    OP_NOP         = 4'h0,
    OP_READ_REG    = 4'h1, // Register read, addr in param_1
    OP_WRITE_REG   = 4'h2, // Register write, data in param_2
    OP_LOAD_START  = 4'h3, // First buffer word
    OP_LOAD_CONT   = 4'h4, // Following buffer words
    OP_LOAD_WEIGHT = 4'h5, // Kernel tap param_1 gets param_2[7:0]
    OP_RUN_CONV    = 4'h6,
    OP_READ_RESULT = 4'h7, // Result index in param_2
    OP_RESET_CONV  = 4'h8  // Abort engine, drop done flag
  } opcode_e;

  // ----------------------------------------
  // Register map
  // ----------------------------------------

  typedef enum logic [3:0] {
    REG_VERSN = 4'd0, // Version, read only
    REG_HWRID = 4'd1, // Hardware id, read only
    REG_CPRM1 = 4'd2, // Matrix size in [3:0]
    REG_STATS = 4'd3  // Busy and done
  } reg_addr_e;

  // Fixed identity values
  localparam logic [15:0] VERSN_VALUE = 16'h6C00;
  localparam logic [15:0] HWRID_VALUE = 16'hB2E9;

  // ----------------------------------------
  // Decoded command
  // ----------------------------------------

  // One registered instruction with its operands, 24 bits
  typedef struct packed {
    opcode_e     opcode;
    logic [3:0]  param_1;
    logic [15:0] param_2;
  } cmd_t;

endpackage

//--- src/aether_regfile.sv
`timescale 1ns/1ps

module aether_regfile #(
  parameter int MaxMatrixSize = 11
) (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  aether_isa_pkg::cmd_t          cmd_i,    // Addr in param_1, data in param_2
  input  logic                          reg_wr_i,
  input  logic                          reg_rd_i,
  input  aether_data_pkg::conv_status_t status_i,
  output logic [3:0]                    cprm1_size_o,
  output logic [15:0]                   reg_rdata_o
);

  localparam logic [3:0] MaxSize = 4'(MaxMatrixSize);
  localparam logic [3:0] MinSize = 4'(aether_data_pkg::KERNEL_SIZE);

  aether_isa_pkg::reg_addr_e addr;
  logic [3:0]                size_q;
  logic [3:0]                size_clamped;

  assign addr         = aether_isa_pkg::reg_addr_e'(cmd_i.param_1);
  assign cprm1_size_o = size_q;

  // Keep N between kernel size and the largest matrix
  always_comb
  begin
    if (cmd_i.param_2 > 16'(MaxSize))
      size_clamped = MaxSize;
    else if (cmd_i.param_2 < 16'(MinSize))
      size_clamped = MinSize;
    else
      size_clamped = cmd_i.param_2[3:0];
  end

  // CPRM1 is the only writable register
  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
      size_q <= MinSize;
    else if (reg_wr_i && addr == aether_isa_pkg::REG_CPRM1)
      size_q <= size_clamped;
  end

  // Read port, data one cycle after the strobe
  always_ff @(posedge clk_i)
  begin
    if (reg_rd_i)
    begin
      case (addr)
        aether_isa_pkg::REG_VERSN: reg_rdata_o <= aether_isa_pkg::VERSN_VALUE;
        aether_isa_pkg::REG_HWRID: reg_rdata_o <= aether_isa_pkg::HWRID_VALUE;
        aether_isa_pkg::REG_CPRM1: reg_rdata_o <= {12'b0, size_q};
        aether_isa_pkg::REG_STATS: reg_rdata_o <= {14'b0, status_i}; // Live flags
        default:                   reg_rdata_o <= '0;
      endcase
    end
  end

endmodule

//--- src/conv_engine.sv
`timescale 1ns/1ps

module conv_engine #(
  parameter int BufferWords   = 64,
  parameter int MaxMatrixSize = 11,
  parameter int ResultDepth   = 81
) (
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  input  logic                           weight_wr_i,
  input  logic [3:0]                     weight_idx_i, // Tap 0 to 8, row-major
  input  aether_data_pkg::weight_t       weight_i,
  input  logic                           run_i,
  input  logic                           clear_i,
  input  logic                           res_rd_i,
  input  logic [$clog2(ResultDepth)-1:0] res_idx_i,
  input  logic [3:0]                     size_i,       // N from CPRM1
  output logic [$clog2(BufferWords)-1:0] buf_raddr_o,
  input  logic [15:0]                    buf_rdata_i,
  output aether_data_pkg::conv_status_t  status_o,
  output aether_data_pkg::result_t       res_rdata_o,
  output logic                           done_o
);

  localparam int BufAddrW = $clog2(BufferWords);
  localparam int ResAddrW = $clog2(ResultDepth);
  localparam int PixW     = $clog2(MaxMatrixSize * MaxMatrixSize); // Pixel index
  localparam int Taps     = aether_data_pkg::KERNEL_SIZE * aether_data_pkg::KERNEL_SIZE;
  localparam logic [3:0] KLast = 4'(aether_data_pkg::KERNEL_SIZE - 1);

  typedef enum logic [1:0] {IDLE, FETCH, DRAIN, DONE} state_e;

  state_e     state_q;
  logic [3:0] size_q;
  logic [3:0] last_rc;           // Last output row and column
  logic [3:0] r_q, c_q;          // Output position
  logic [3:0] kr_q, kc_q;        // Kernel tap
  logic [3:0] tap;

  logic [PixW-1:0] row, col, pix_idx;

  // Fetch stage, aligned with the buffer read
  logic       s1_valid_q;
  logic       s1_hi_q;           // Odd pixel, high byte
  logic [3:0] s1_tap_q;

  aether_data_pkg::weight_t w_q [Taps];
  aether_data_pkg::pixel_t  pix_sel;
  logic signed [15:0]       prod;
  aether_data_pkg::acc_t    acc_q, acc_next;

  aether_data_pkg::result_t res_mem [ResultDepth];
  logic [ResAddrW-1:0]      res_widx_q;

  // ----------------------------------------
  // Address generator
  // ----------------------------------------

  assign last_rc     = size_q - 4'd3;
  assign tap         = kr_q * 4'(aether_data_pkg::KERNEL_SIZE) + kc_q;
  assign row         = PixW'(r_q + kr_q);
  assign col         = PixW'(c_q + kc_q);
  assign pix_idx     = row * PixW'(size_q) + col;
  assign buf_raddr_o = BufAddrW'(pix_idx >> 1); // Two pixels per word

  assign status_o.busy = (state_q == FETCH) || (state_q == DRAIN);
  assign status_o.done = (state_q == DONE);
  assign done_o        = status_o.done;

  // Walks taps, then columns, then rows
  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      state_q <= IDLE;
      size_q  <= 4'd3;
      r_q     <= '0;
      c_q     <= '0;
      kr_q    <= '0;
      kc_q    <= '0;
    end
    else if (clear_i)
      state_q <= IDLE; // Drops done
    else if (run_i)
    begin
      state_q <= FETCH;
      size_q  <= size_i; // Size held for the whole run
      r_q     <= '0;
      c_q     <= '0;
      kr_q    <= '0;
      kc_q    <= '0;
    end
    else if (state_q == FETCH)
    begin
      kc_q <= (kc_q == KLast) ? 4'd0 : kc_q + 4'd1;
      if (kc_q == KLast)
      begin
        kr_q <= (kr_q == KLast) ? 4'd0 : kr_q + 4'd1;
        if (kr_q == KLast)
        begin
          c_q <= (c_q == last_rc) ? 4'd0 : c_q + 4'd1;
          if (c_q == last_rc)
          begin
            r_q <= r_q + 4'd1;
            if (r_q == last_rc)
              state_q <= DRAIN; // Last fetch issued
          end
        end
      end
    end
    else if (state_q == DRAIN)
      state_q <= DONE; // Last MAC writes this edge
  end

  // ----------------------------------------
  // MAC and result memory
  // ----------------------------------------

  assign pix_sel  = s1_hi_q ? buf_rdata_i[15:8] : buf_rdata_i[7:0];
  assign prod     = pix_sel * w_q[s1_tap_q];
  assign acc_next = ((s1_tap_q == 4'd0) ? '0 : acc_q) + aether_data_pkg::acc_t'(prod);

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      s1_valid_q <= 1'b0;
      res_widx_q <= '0;
    end
    else
    begin
      s1_valid_q <= (state_q == FETCH) && !run_i && !clear_i;
      if (run_i)
        res_widx_q <= '0;
      else if (s1_valid_q && s1_tap_q == 4'(Taps - 1))
        res_widx_q <= res_widx_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i)
  begin
    s1_hi_q  <= pix_idx[0];
    s1_tap_q <= tap;
    if (s1_valid_q)
      acc_q <= acc_next;
    if (s1_valid_q && s1_tap_q == 4'(Taps - 1))
      res_mem[res_widx_q] <= acc_next[15:0]; // Truncate to 16 bits
    if (weight_wr_i && weight_idx_i < 4'(Taps))
      w_q[weight_idx_i] <= weight_i;
    if (res_rd_i)
      res_rdata_o <= res_mem[res_idx_i];
  end

endmodule

//--- src/input_buffer.sv
`timescale 1ns/1ps

module input_buffer #(
  parameter int BufferWords = 64
) (
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  input  logic                           load_start_i, // Write at word 0
  input  logic                           load_cont_i,  // Write at next word
  input  logic [15:0]                    wdata_i,      // Two packed pixels
  input  logic [$clog2(BufferWords)-1:0] raddr_i,
  output logic [15:0]                    rdata_o
);

  localparam int AddrW = $clog2(BufferWords);
  localparam logic [AddrW-1:0] LastWord = AddrW'(BufferWords - 1);

  logic [15:0]      mem [BufferWords];
  logic [AddrW-1:0] waddr_q;  // Next write slot
  logic [AddrW-1:0] waddr;
  logic             wr_en;

  assign wr_en = load_start_i || load_cont_i;
  assign waddr = load_start_i ? '0 : waddr_q;

  // ----------------------------------------
  // Write address counter
  // ----------------------------------------

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
      waddr_q <= '0;
    else if (wr_en)
      waddr_q <= (waddr == LastWord) ? LastWord : waddr + 1'b1; // Saturate
  end

  // ----------------------------------------
  // Storage
  // ----------------------------------------

  always_ff @(posedge clk_i)
  begin
    if (wr_en)
      mem[waddr] <= wdata_i;
    rdata_o <= mem[raddr_i]; // Registered read for the engine
  end

endmodule
